// File: hw/sys_params.svh
// widths and 1080p timing defaults shared by all blocks; single clock domain assumed
`ifndef SYS_PARAMS_SVH
`define SYS_PARAMS_SVH

// word widths
`define SYS_IO_W 16
`define SYS_TIM_W 12
`define SYS_AUD_W 16
// top bit of attenuation is mute
`define SYS_ATT_W 5

// CEA timing for 1920x1080 at 60 Hz
`define SYS_DEF_WIDTH 12'd1920
`define SYS_DEF_HFP 12'd88
`define SYS_DEF_HS 12'd44
`define SYS_DEF_HBP 12'd148
`define SYS_DEF_HEIGHT 12'd1080
`define SYS_DEF_VFP 12'd4
`define SYS_DEF_VS 12'd5
`define SYS_DEF_VBP 12'd36

// window loop length is a power of two
`define SYS_WIN_STEPS 8
`endif

// File: hw/sys_io_pkg.sv
// host port types; only the opcodes listed here are decoded, others are ignored
`include "sys_params.svh"

package sys_io_pkg;

	////////////////////////////////////////
	// host command opcodes
	////////////////////////////////////////
	typedef enum logic [7:0] {
		CMD_TIMING  = 8'h20,
		CMD_LED     = 8'h25,
		CMD_VOLUME  = 8'h26,
		CMD_VSET    = 8'h27,
		CMD_WAIT_VS = 8'h30
	} cmd_e;

	// header word, opcode in the low byte
	typedef struct packed {
		logic [`SYS_IO_W-9:0] rsv;
		cmd_e op;
	} io_hdr_t;

	// led word, overtake mask over state
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} io_led_t;

	typedef union packed {
		io_hdr_t hdr;
		io_led_t led;
	} io_word_u;

endpackage

// File: hw/sys_video_pkg.sv
// video timing types; field order matches the payload order of the timing command
`include "sys_params.svh"

package sys_video_pkg;

	// timing field index, payload word n writes field n
	typedef enum logic [2:0] {
		TIM_WIDTH,
		TIM_HFP,
		TIM_HS,
		TIM_HBP,
		TIM_HEIGHT,
		TIM_VFP,
		TIM_VS,
		TIM_VBP
	} tim_idx_e;

	// one timing value in pixels or lines
	typedef logic [`SYS_TIM_W-1:0] tim_t;

endpackage

// File: hw/sys_cmd_ctrl.sv
// host must keep i_io_uio high for a whole command; words after the 8th timing word are dropped
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_cmd_ctrl (
	input  logic                     clk,
	input  logic                     resetd,
	input  logic                     i_io_clk,
	input  logic                     i_io_uio,
	input  logic [`SYS_IO_W-1:0]     i_io_din,
	input  logic                     i_vsync,
	input  logic [7:0]               i_led_status,
	output logic                     o_io_ack,
	output logic                     o_tim_wr,
	output sys_video_pkg::tim_idx_e  o_tim_idx,
	output sys_video_pkg::tim_t      o_tim_val,
	output logic                     o_vset_wr,
	output sys_video_pkg::tim_t      o_vset_val,
	output logic [`SYS_ATT_W-1:0]    o_vol_att,
	output logic [7:0]               o_led
);

	logic rack;
	logic strobe;
	logic hold;
	logic word_vld;
	sys_io_pkg::io_word_u word_q;
	logic has_cmd;
	sys_io_pkg::cmd_e cmd;
	logic [3:0] cnt;
	logic pay_vld;
	logic vs_wait;
	logic vs_d0;
	logic vs_d1;
	logic vs_d2;
	logic [7:0] led_ovr;
	logic [7:0] led_state;

	////////////////////////////////////////
	// echo handshake
	////////////////////////////////////////
	assign strobe = i_io_clk & ~rack;
	// frame wait only holds the ack once payload has started
	assign hold = vs_wait & (cnt != 4'd0);

	always_ff @(posedge clk) begin
		if (resetd) begin
			rack <= 1'b0;
			o_io_ack <= 1'b0;
		end else if (i_io_clk | ~hold) begin
			rack <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	always_ff @(posedge clk) begin
		if (resetd)
			word_vld <= 1'b0;
		else
			word_vld <= strobe;
	end

	always_ff @(posedge clk) begin
		if (strobe)
			word_q <= i_io_din;
	end

	////////////////////////////////////////
	// command decode
	////////////////////////////////////////
	assign pay_vld = word_vld & i_io_uio & has_cmd;

	// timing and vset writes land in the bank on the next edge
	assign o_tim_wr = pay_vld & (cmd == sys_io_pkg::CMD_TIMING) & ~cnt[3];
	assign o_tim_idx = sys_video_pkg::tim_idx_e'(cnt[2:0]);
	assign o_tim_val = word_q[`SYS_TIM_W-1:0];
	assign o_vset_wr = pay_vld & (cmd == sys_io_pkg::CMD_VSET);
	assign o_vset_val = word_q[`SYS_TIM_W-1:0];

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cnt <= 4'd0;
			vs_wait <= 1'b0;
			vs_d0 <= 1'b0;
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
			o_vol_att <= '0;
			led_ovr <= 8'd0;
		end else begin
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
			end else if (word_vld) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd <= word_q.hdr.op;
					cnt <= 4'd0;
				end else begin
					// saturates at 8
					if (!cnt[3])
						cnt <= cnt + 4'd1;
					if (cmd == sys_io_pkg::CMD_LED)
						led_ovr <= word_q.led.overtake;
					if (cmd == sys_io_pkg::CMD_VOLUME)
						o_vol_att <= word_q[`SYS_ATT_W-1:0];
				end
			end
			// vsync must hold two samples before the edge counts
			vs_d0 <= i_vsync;
			if (vs_d0 == i_vsync)
				vs_d1 <= vs_d0;
			vs_d2 <= vs_d1;
			if (~vs_d2 & vs_d1)
				vs_wait <= 1'b0;
			if (word_vld & i_io_uio & ~has_cmd & (word_q.hdr.op == sys_io_pkg::CMD_WAIT_VS))
				vs_wait <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pay_vld && cmd == sys_io_pkg::CMD_LED)
			led_state <= word_q.led.state;
	end

	// overtaken bits come from the host, the rest from status
	assign o_led = (led_ovr & led_state) | (~led_ovr & i_led_status);

endmodule

// File: hw/sys_timing_regs.sv
// timing bank resets to 1080p60; totals are combinational and wrap at 12 bits
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_timing_regs (
	input  logic                    clk,
	input  logic                    resetd,
	input  logic                    i_tim_wr,
	input  sys_video_pkg::tim_idx_e i_tim_idx,
	input  sys_video_pkg::tim_t     i_tim_val,
	input  logic                    i_vset_wr,
	input  sys_video_pkg::tim_t     i_vset_val,
	output sys_video_pkg::tim_t     o_width,
	output sys_video_pkg::tim_t     o_height,
	output sys_video_pkg::tim_t     o_vset,
	output sys_video_pkg::tim_t     o_htotal,
	output sys_video_pkg::tim_t     o_vtotal
);

	sys_video_pkg::tim_t tim [8];

	always_ff @(posedge clk) begin
		if (resetd) begin
			tim[sys_video_pkg::TIM_WIDTH] <= `SYS_DEF_WIDTH;
			tim[sys_video_pkg::TIM_HFP] <= `SYS_DEF_HFP;
			tim[sys_video_pkg::TIM_HS] <= `SYS_DEF_HS;
			tim[sys_video_pkg::TIM_HBP] <= `SYS_DEF_HBP;
			tim[sys_video_pkg::TIM_HEIGHT] <= `SYS_DEF_HEIGHT;
			tim[sys_video_pkg::TIM_VFP] <= `SYS_DEF_VFP;
			tim[sys_video_pkg::TIM_VS] <= `SYS_DEF_VS;
			tim[sys_video_pkg::TIM_VBP] <= `SYS_DEF_VBP;
			o_vset <= '0;
		end else begin
			// only changed values are written
			if (i_tim_wr && tim[i_tim_idx] != i_tim_val)
				tim[i_tim_idx] <= i_tim_val;
			if (i_vset_wr)
				o_vset <= i_vset_val;
		end
	end

	assign o_width = tim[sys_video_pkg::TIM_WIDTH];
	assign o_height = tim[sys_video_pkg::TIM_HEIGHT];

	assign o_htotal = tim[sys_video_pkg::TIM_WIDTH] + tim[sys_video_pkg::TIM_HFP] +
		tim[sys_video_pkg::TIM_HS] + tim[sys_video_pkg::TIM_HBP];
	assign o_vtotal = tim[sys_video_pkg::TIM_HEIGHT] + tim[sys_video_pkg::TIM_VFP] +
		tim[sys_video_pkg::TIM_VS] + tim[sys_video_pkg::TIM_VBP];

endmodule

// File: hw/sys_aspect_window.sv
// window settles within two loop passes of the last input change; vset may exceed frame width
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_aspect_window (
	input  logic                clk,
	input  logic                resetd,
	input  sys_video_pkg::tim_t i_width,
	input  sys_video_pkg::tim_t i_height,
	input  sys_video_pkg::tim_t i_vset,
	input  logic [7:0]          i_arx,
	input  logic [7:0]          i_ary,
	output sys_video_pkg::tim_t o_hmin,
	output sys_video_pkg::tim_t o_hmax,
	output sys_video_pkg::tim_t o_vmin,
	output sys_video_pkg::tim_t o_vmax
);

	localparam int STEP_W = $clog2(`SYS_WIN_STEPS);
	localparam int CALC_W = `SYS_TIM_W + 8;

	logic [STEP_W-1:0] step;
	logic ar_ok;
	logic [CALC_W-1:0] wcalc;
	logic [CALC_W-1:0] hcalc;
	sys_video_pkg::tim_t wbase;
	sys_video_pkg::tim_t videow;
	sys_video_pkg::tim_t videoh;
	sys_video_pkg::tim_t hoff;
	sys_video_pkg::tim_t voff;

	assign ar_ok = (i_arx != 8'd0) && (i_ary != 8'd0);
	assign wbase = (i_vset != '0) ? i_vset : i_height;

	// centring offsets, truncated
	assign hoff = (i_width - videow) >> 1;
	assign voff = (i_height - videoh) >> 1;

	////////////////////////////////////////
	// loop control and window outputs
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (resetd) begin
			step <= '0;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else begin
			step <= step + 1'b1;
			if (step == '0 && !ar_ok) begin
				// no aspect given, show the full frame
				o_hmin <= '0;
				o_hmax <= i_width - 1'b1;
				o_vmin <= '0;
				o_vmax <= i_height - 1'b1;
				step <= '0;
			end else if (step == STEP_W'(`SYS_WIN_STEPS - 1)) begin
				o_hmin <= hoff;
				o_hmax <= hoff + videow - 1'b1;
				o_vmin <= voff;
				o_vmax <= voff + videoh - 1'b1;
			end
		end
	end

	// targets at step 0, clamp two steps before the end
	always_ff @(posedge clk) begin
		if (step == '0 && ar_ok) begin
			wcalc <= (CALC_W'(wbase) * CALC_W'(i_arx)) / CALC_W'(i_ary);
			hcalc <= (CALC_W'(i_width) * CALC_W'(i_ary)) / CALC_W'(i_arx);
		end
		if (step == STEP_W'(`SYS_WIN_STEPS - 2)) begin
			videow <= (i_vset == '0 && wcalc > CALC_W'(i_width)) ? i_width : wcalc[`SYS_TIM_W-1:0];
			videoh <= (i_vset != '0) ? i_vset :
				(hcalc > CALC_W'(i_height)) ? i_height : hcalc[`SYS_TIM_W-1:0];
		end
	end

endmodule

// File: hw/sys_audio_mix.sv
// one channel; the 17-bit cross-mix sum wraps before attenuation, output clamps to 16 bits
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_audio_mix (
	input  logic                  clk,
	input  logic                  resetd,
	input  logic [`SYS_AUD_W-1:0] i_core,
	input  logic [`SYS_AUD_W-1:0] i_linux,
	input  logic [`SYS_AUD_W-1:0] i_pre,
	input  logic                  i_signed,
	input  logic [1:0]            i_mix,
	input  logic [`SYS_ATT_W-1:0] i_att,
	output logic [`SYS_AUD_W-1:0] o_pre,
	output logic [`SYS_AUD_W-1:0] o_out
);

	localparam int SUM_W = `SYS_AUD_W + 1;

	logic [`SYS_AUD_W-1:0] core_d1;
	logic [`SYS_AUD_W-1:0] core_d2;
	logic [`SYS_AUD_W-1:0] core_ok;
	logic signed [SUM_W-1:0] core_w;
	logic signed [SUM_W-1:0] pre_s;
	logic signed [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] mixed;
	logic signed [SUM_W-1:0] att_q;

	// unsigned core samples are halved to fit next to signed linux audio
	assign core_w = i_signed ? $signed({core_ok[`SYS_AUD_W-1], core_ok}) :
		$signed({2'b00, core_ok[`SYS_AUD_W-1:1]});
	assign pre_s = $signed({i_pre[`SYS_AUD_W-1], i_pre});

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1 <= '0;
			core_d2 <= '0;
			core_ok <= '0;
			sum <= '0;
			mixed <= '0;
			att_q <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// glitch filter, two equal samples in a row
			core_d1 <= i_core;
			core_d2 <= core_d1;
			if (core_d1 == core_d2)
				core_ok <= core_d1;
			sum <= core_w + $signed({i_linux[`SYS_AUD_W-1], i_linux});
			o_pre <= sum[SUM_W-1:1];
			case (i_mix)
				2'd0: mixed <= sum;
				2'd1: mixed <= sum - (sum >>> 3) + (pre_s >>> 2);
				2'd2: mixed <= sum - (sum >>> 2) + (pre_s >>> 1);
				default: mixed <= (sum >>> 1) + pre_s;
			endcase
			if (i_att[`SYS_ATT_W-1])
				att_q <= '0;
			else
				att_q <= mixed >>> i_att[`SYS_ATT_W-2:0];
			// saturate when the top two bits disagree
			o_out <= (att_q[SUM_W-1] ^ att_q[SUM_W-2]) ?
				{att_q[SUM_W-1], {(`SYS_AUD_W-1){~att_q[SUM_W-1]}}} : att_q[`SYS_AUD_W-1:0];
		end
	end

endmodule

// File: hw/sys_top.sv
// single clock top; host port words are 16 bits, both audio channels share volume and mode
`timescale 1ns/1ps
`include "sys_params.svh"

module sys_top (
	input  logic                  clk,
	input  logic                  resetd,
	input  logic                  i_io_clk,
	input  logic                  i_io_uio,
	input  logic [`SYS_IO_W-1:0]  i_io_din,
	output logic                  o_io_ack,
	input  logic                  i_vsync,
	input  logic [7:0]            i_led_status,
	output logic [7:0]            o_led,
	input  logic [7:0]            i_arx,
	input  logic [7:0]            i_ary,
	output logic [`SYS_TIM_W-1:0] o_hmin,
	output logic [`SYS_TIM_W-1:0] o_hmax,
	output logic [`SYS_TIM_W-1:0] o_vmin,
	output logic [`SYS_TIM_W-1:0] o_vmax,
	output logic [`SYS_TIM_W-1:0] o_htotal,
	output logic [`SYS_TIM_W-1:0] o_vtotal,
	input  logic [`SYS_AUD_W-1:0] i_core_l,
	input  logic [`SYS_AUD_W-1:0] i_core_r,
	input  logic [`SYS_AUD_W-1:0] i_linux_l,
	input  logic [`SYS_AUD_W-1:0] i_linux_r,
	input  logic                  i_audio_signed,
	input  logic [1:0]            i_audio_mix,
	output logic [`SYS_AUD_W-1:0] o_audio_l,
	output logic [`SYS_AUD_W-1:0] o_audio_r
);

	logic tim_wr;
	sys_video_pkg::tim_idx_e tim_idx;
	logic [`SYS_TIM_W-1:0] tim_val;
	logic vset_wr;
	logic [`SYS_TIM_W-1:0] vset_val;
	logic [`SYS_ATT_W-1:0] vol_att;
	logic [`SYS_TIM_W-1:0] width;
	logic [`SYS_TIM_W-1:0] height;
	logic [`SYS_TIM_W-1:0] vset;
	logic [`SYS_AUD_W-1:0] pre_l;
	logic [`SYS_AUD_W-1:0] pre_r;

	////////////////////////////////////////
	// host control and video
	////////////////////////////////////////
	sys_cmd_ctrl cmd_ctrl (
		.clk(clk), .resetd(resetd), .i_io_clk(i_io_clk), .i_io_uio(i_io_uio),
		.i_io_din(i_io_din), .i_vsync(i_vsync), .i_led_status(i_led_status),
		.o_io_ack(o_io_ack), .o_tim_wr(tim_wr), .o_tim_idx(tim_idx), .o_tim_val(tim_val),
		.o_vset_wr(vset_wr), .o_vset_val(vset_val), .o_vol_att(vol_att), .o_led(o_led)
	);

	sys_timing_regs timing_regs (
		.clk(clk), .resetd(resetd), .i_tim_wr(tim_wr), .i_tim_idx(tim_idx),
		.i_tim_val(tim_val), .i_vset_wr(vset_wr), .i_vset_val(vset_val),
		.o_width(width), .o_height(height), .o_vset(vset),
		.o_htotal(o_htotal), .o_vtotal(o_vtotal)
	);

	sys_aspect_window aspect_window (
		.clk(clk), .resetd(resetd), .i_width(width), .i_height(height), .i_vset(vset),
		.i_arx(i_arx), .i_ary(i_ary),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax)
	);

	////////////////////////////////////////
	// audio, pre-outputs cross over
	////////////////////////////////////////
	sys_audio_mix audio_l (
		.clk(clk), .resetd(resetd), .i_core(i_core_l), .i_linux(i_linux_l), .i_pre(pre_r),
		.i_signed(i_audio_signed), .i_mix(i_audio_mix), .i_att(vol_att),
		.o_pre(pre_l), .o_out(o_audio_l)
	);

	sys_audio_mix audio_r (
		.clk(clk), .resetd(resetd), .i_core(i_core_r), .i_linux(i_linux_r), .i_pre(pre_l),
		.i_signed(i_audio_signed), .i_mix(i_audio_mix), .i_att(vol_att),
		.o_pre(pre_r), .o_out(o_audio_r)
	);

endmodule

// File: dv/tb_sys_top.sv
// run from the project root so dv/sys_patterns.hex resolves; the record list must end with op ff
`timescale 1ns/1ps
`include "sys_params.svh"

module tb_sys_top;

	logic clk;
	logic resetd;
	logic io_clk;
	logic io_uio;
	logic [`SYS_IO_W-1:0] io_din;
	logic io_ack;
	logic vsync;
	logic [7:0] led_status;
	logic [7:0] led;
	logic [7:0] arx;
	logic [7:0] ary;
	logic [`SYS_TIM_W-1:0] hmin;
	logic [`SYS_TIM_W-1:0] hmax;
	logic [`SYS_TIM_W-1:0] vmin;
	logic [`SYS_TIM_W-1:0] vmax;
	logic [`SYS_TIM_W-1:0] htotal;
	logic [`SYS_TIM_W-1:0] vtotal;
	logic [`SYS_AUD_W-1:0] core_l;
	logic [`SYS_AUD_W-1:0] core_r;
	logic [`SYS_AUD_W-1:0] linux_l;
	logic [`SYS_AUD_W-1:0] linux_r;
	logic audio_signed;
	logic [1:0] audio_mix;
	logic [`SYS_AUD_W-1:0] audio_l;
	logic [`SYS_AUD_W-1:0] audio_r;
	// record layout {op[31:24], select[23:16], value[15:0]}
	logic [31:0] recs [0:255];
	int rec_count;
	int rec_idx;
	int run_cycles;
	int errors;
	int checks;
	int seed;

	sys_top sys_top_inst (
		.clk(clk), .resetd(resetd), .i_io_clk(io_clk), .i_io_uio(io_uio), .i_io_din(io_din),
		.o_io_ack(io_ack), .i_vsync(vsync), .i_led_status(led_status), .o_led(led),
		.i_arx(arx), .i_ary(ary), .o_hmin(hmin), .o_hmax(hmax), .o_vmin(vmin), .o_vmax(vmax),
		.o_htotal(htotal), .o_vtotal(vtotal), .i_core_l(core_l), .i_core_r(core_r),
		.i_linux_l(linux_l), .i_linux_r(linux_r), .i_audio_signed(audio_signed),
		.i_audio_mix(audio_mix), .o_audio_l(audio_l), .o_audio_r(audio_r)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// host port and stimulus helpers
	////////////////////////////////////////
	// raise io_clk, wait for the echo, optionally wait for it to drop again
	task automatic send_word(input logic [15:0] value, input logic wait_fall);
		repeat ($urandom % 4) @(posedge clk);
		@(posedge clk);
		io_din <= value;
		io_clk <= 1'b1;
		@(posedge clk);
		while (!io_ack) @(posedge clk);
		io_clk <= 1'b0;
		if (wait_fall) begin
			@(posedge clk);
			while (io_ack) @(posedge clk);
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: got 0x%04h, expected 0x%04h at %0t", name, actual, expected,
				$time);
		end
	endtask

	task automatic set_input(input logic [7:0] sel, input logic [15:0] value);
		@(posedge clk);
		case (sel)
			8'd0: core_l <= value;
			8'd1: core_r <= value;
			8'd2: linux_l <= value;
			8'd3: linux_r <= value;
			8'd4: audio_signed <= value[0];
			8'd5: audio_mix <= value[1:0];
			8'd6: arx <= value[7:0];
			8'd7: ary <= value[7:0];
			8'd8: led_status <= value[7:0];
			default: begin
				errors++;
				$display("pattern file names input %0d, which does not exist", sel);
			end
		endcase
	endtask

	// outputs are compared away from the rising edge
	task automatic check_output(input logic [7:0] sel, input logic [15:0] value);
		@(negedge clk);
		case (sel)
			8'd0: check_value("o_htotal", 16'(htotal), value);
			8'd1: check_value("o_vtotal", 16'(vtotal), value);
			8'd2: check_value("o_led", 16'(led), value);
			8'd3: check_value("o_io_ack", 16'(io_ack), value);
			8'd4: check_value("o_hmin", 16'(hmin), value);
			8'd5: check_value("o_hmax", 16'(hmax), value);
			8'd6: check_value("o_vmin", 16'(vmin), value);
			8'd7: check_value("o_vmax", 16'(vmax), value);
			8'd8: check_value("o_audio_l", audio_l, value);
			8'd9: check_value("o_audio_r", audio_r, value);
			default: begin
				errors++;
				$display("pattern file names output %0d, which does not exist", sel);
			end
		endcase
	endtask

	task automatic run_record(input logic [31:0] rec);
		case (rec[31:24])
			8'h01: begin
				@(posedge clk);
				io_uio <= rec[0];
			end
			8'h02: send_word(rec[15:0], 1'b1);
			8'h03: send_word(rec[15:0], 1'b0);
			8'h04: set_input(rec[23:16], rec[15:0]);
			8'h05: begin
				@(posedge clk);
				vsync <= 1'b1;
				repeat (rec[15:0]) @(posedge clk);
				vsync <= 1'b0;
			end
			8'h06: begin
				@(posedge clk);
				while (io_ack) @(posedge clk);
			end
			8'h07: repeat (rec[15:0]) @(posedge clk);
			8'h08: check_output(rec[23:16], rec[15:0]);
			default: begin
				errors++;
				$display("pattern record 0x%08h has an unknown opcode", rec);
			end
		endcase
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		clk = 1'b0;
		resetd = 1'b1;
		io_clk = 1'b0;
		io_uio = 1'b0;
		io_din = '0;
		vsync = 1'b0;
		led_status = 8'd0;
		arx = 8'd0;
		ary = 8'd0;
		core_l = '0;
		core_r = '0;
		linux_l = '0;
		linux_r = '0;
		audio_signed = 1'b0;
		audio_mix = 2'd0;
		errors = 0;
		checks = 0;
		rec_count = 0;
		seed = $urandom(32'h1bb8);
		$readmemh("dv/sys_patterns.hex", recs);
		while (rec_count < 256 && recs[rec_count][31:24] !== 8'hff)
			rec_count++;
		if (rec_count == 256) begin
			errors++;
			$display("pattern file has no end record, nothing was run");
			rec_count = 0;
		end
		run_cycles = 4000 * (rec_count + 1);
		repeat (4) @(posedge clk);
		resetd <= 1'b0;
		for (rec_idx = 0; rec_idx < rec_count; rec_idx++)
			run_record(recs[rec_idx]);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog scaled by the number of records
	initial begin
		wait (run_cycles != 0);
		repeat (run_cycles) @(posedge clk);
		$display("timeout: the pattern run did not finish within %0d cycles", run_cycles);
		$display("test failed");
		$finish;
	end

endmodule

// File: dv/sys_patterns.hex
// one record per word: op(8) select(8) value(16); 01 uio, 02 word, 03 held word, 04 set input
// 05 vsync cycles, 06 wait ack low, 07 idle cycles, 08 check output, ff end of run
08000898 08010465 040800A5 07000002 080200A5 08030000 // reset state and led status
01000001 02000020 02000500 0200006E 02000028 020000DC // timing header, 720p horizontal
020002D0 02000005 02000005 02000014 // 720p vertical fields
02000100 02000200 01000000 07000004 // two extra words are dropped
08000672 080102EE // new totals
01000001 02000025 0200F03C 01000000 07000004 08020035 // led overtake f0, state 3c
04060004 04070003 07000010 // aspect 4:3, vset 0
080400A0 0805045F 08060000 080702CF
01000001 02000027 02000258 01000000 07000010 // vset 600
080400F0 0805040F 0806003C 08070293
04060000 07000010 08040000 080504FF 08060000 080702CF // zero aspect gives full frame
04001000 0401F000 04020800 04030100 04040001 04050000 07000008 08081800 0809F100 // mix 0
04050001 07000008 08081320 0809F5E0 // mix 1
04050002 07000008 08080E40 0809FAC0 // mix 2
04050003 07000008 08080480 08090480 // mix 3
04040000 04050000 04008000 07000008 08084800 08097900 // unsigned core
04040001 04007000 04027000 04018000 04038000 07000008 08087FFF 08098000 // clamp both ways
01000001 02000026 02000002 01000000 07000008 08083800 0809C000 // attenuate by 2
01000001 02000026 02000010 01000000 07000008 08080000 08090000 // mute
01000001 02000030 03000000 07000014 08030001 // frame wait holds the ack
05000004 06000000 08030000 01000000 // vsync releases it
FF000000

// File: tb.f
+incdir+hw
hw/sys_io_pkg.sv
hw/sys_video_pkg.sv
hw/sys_cmd_ctrl.sv
hw/sys_timing_regs.sv
hw/sys_aspect_window.sv
hw/sys_audio_mix.sv
hw/sys_top.sv
dv/tb_sys_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_sys_top -Mdir obj_dir -o tb_sys_top
./obj_dir/tb_sys_top > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
exit 0
